// ==== verilog/axi_mux_pkg.sv ====
package axi_mux_pkg;

  // --------------------------------------------------------------------------
  // Widths and limits
  // --------------------------------------------------------------------------
  localparam int unsigned NO_SLV_PORTS   = 4;
  localparam int unsigned PORT_IDX_WIDTH = 2;                  // Bits of a port index
  localparam int unsigned SLV_ID_WIDTH   = 4;
  localparam int unsigned MST_ID_WIDTH   = SLV_ID_WIDTH + PORT_IDX_WIDTH;
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int unsigned LEN_WIDTH      = 8;
  localparam int unsigned MAX_W_TRANS    = 4;                  // Depth of the W route FIFO
  localparam int unsigned FIFO_PTR_WIDTH = $clog2(MAX_W_TRANS);
  localparam int unsigned FIFO_CNT_WIDTH = $clog2(MAX_W_TRANS + 1);

  // --------------------------------------------------------------------------
  // Scalar types
  // --------------------------------------------------------------------------
  typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;
  typedef logic [SLV_ID_WIDTH-1:0]   slv_id_t;
  typedef logic [MST_ID_WIDTH-1:0]   mst_id_t;  // {port index, slave ID}
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [LEN_WIDTH-1:0]      len_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // AW lock, set while a pushed AW waits for the master
  typedef enum logic {
    AW_IDLE,
    AW_LOCKED
  } aw_state_e;

  // --------------------------------------------------------------------------
  // Channel payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_aw_chan_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_aw_chan_t;

  typedef slv_aw_chan_t slv_ar_chan_t;  // Same layout as AW
  typedef mst_aw_chan_t mst_ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    slv_id_t   id;
    axi_resp_e resp;
  } slv_b_chan_t;

  typedef struct packed {
    mst_id_t   id;
    axi_resp_e resp;
  } mst_b_chan_t;

  typedef struct packed {
    slv_id_t   id;
    data_t     data;
    axi_resp_e resp;
    logic      last;
  } slv_r_chan_t;

  typedef struct packed {
    mst_id_t   id;
    data_t     data;
    axi_resp_e resp;
    logic      last;
  } mst_r_chan_t;

  // --------------------------------------------------------------------------
  // Port bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    slv_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } slv_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    slv_b_chan_t b;
    logic        b_valid;
    logic        ar_ready;
    slv_r_chan_t r;
    logic        r_valid;
  } slv_resp_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    mst_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } mst_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    mst_b_chan_t b;
    logic        b_valid;
    logic        ar_ready;
    mst_r_chan_t r;
    logic        r_valid;
  } mst_resp_t;

endpackage

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter import axi_mux_pkg::*; (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [NO_SLV_PORTS-1:0] req_i,   // Valids of the ports
  input  logic                    gnt_i,   // Downstream ready
  output logic [NO_SLV_PORTS-1:0] gnt_o,   // Readies back to the ports
  output logic                    req_o,   // Downstream valid
  output port_idx_t               idx_o
);

  port_idx_t prio_q;      // Port with the highest priority
  port_idx_t lock_idx_q;
  logic      lock_q;
  port_idx_t rr_idx;
  logic      rr_found;

  // First requesting port, searching upward from the priority pointer
  always_comb begin
    rr_idx   = prio_q;
    rr_found = 1'b0;
    for (int i = 0; i < NO_SLV_PORTS; i++) begin
      if (!rr_found && req_i[prio_q + port_idx_t'(i)]) begin
        rr_idx   = prio_q + port_idx_t'(i);
        rr_found = 1'b1;
      end
    end
  end

  assign req_o = |req_i;
  assign idx_o = lock_q ? lock_idx_q : rr_idx;  // A stalled choice stays put

  always_comb begin
    gnt_o = '0;
    if (req_o) begin
      gnt_o[idx_o] = gnt_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= req_o & ~gnt_i;
      if (req_o && !gnt_i) begin
        lock_idx_q <= idx_o;
      end
      // Winner drops to the lowest priority
      if (req_o && gnt_i) begin
        prio_q <= idx_o + port_idx_t'(1);
      end
    end
  end

endmodule

// ==== verilog/w_route_fifo.sv ====
`timescale 1ns/1ps

module w_route_fifo import axi_mux_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      push_i,
  input  port_idx_t data_i,
  input  logic      pop_i,
  output port_idx_t data_o,   // Head entry
  output logic      full_o,
  output logic      empty_o
);

  port_idx_t                 mem_q [MAX_W_TRANS];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
  logic [FIFO_CNT_WIDTH-1:0] cnt_q;
  logic                      do_push;
  logic                      do_pop;

  assign full_o  = (cnt_q == FIFO_CNT_WIDTH'(MAX_W_TRANS));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_WIDTH'(MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_WIDTH'(MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;           // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== verilog/axi_mux_write.sv ====
`timescale 1ns/1ps

module axi_mux_write import axi_mux_pkg::*; (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Slave ports
  input  slv_aw_chan_t [NO_SLV_PORTS-1:0] slv_aw_i,
  input  logic         [NO_SLV_PORTS-1:0] slv_aw_valid_i,
  output logic         [NO_SLV_PORTS-1:0] slv_aw_ready_o,
  input  w_chan_t      [NO_SLV_PORTS-1:0] slv_w_i,
  input  logic         [NO_SLV_PORTS-1:0] slv_w_valid_i,
  output logic         [NO_SLV_PORTS-1:0] slv_w_ready_o,
  output slv_b_chan_t  [NO_SLV_PORTS-1:0] slv_b_o,
  output logic         [NO_SLV_PORTS-1:0] slv_b_valid_o,
  input  logic         [NO_SLV_PORTS-1:0] slv_b_ready_i,
  // Master port
  output mst_aw_chan_t                    mst_aw_o,
  output logic                            mst_aw_valid_o,
  input  logic                            mst_aw_ready_i,
  output w_chan_t                         mst_w_o,
  output logic                            mst_w_valid_o,
  input  logic                            mst_w_ready_i,
  input  mst_b_chan_t                     mst_b_i,
  input  logic                            mst_b_valid_i,
  output logic                            mst_b_ready_o
);

  logic      aw_valid;        // Arbiter has a winner
  logic      aw_ready;        // Transfer towards the arbiter
  port_idx_t aw_idx;
  aw_state_e aw_state_q, aw_state_d;

  logic      w_fifo_push, w_fifo_pop;
  logic      w_fifo_full, w_fifo_empty;
  port_idx_t w_fifo_data;

  port_idx_t b_sel;

  // --------------------------------------------------------------------------
  // AW channel
  // --------------------------------------------------------------------------
  rr_arbiter i_aw_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_aw_valid_i ),
    .gnt_i    ( aw_ready       ),
    .gnt_o    ( slv_aw_ready_o ),
    .req_o    ( aw_valid       ),
    .idx_o    ( aw_idx         )
  );

  // Winner's AW with its port index in front of the ID
  assign mst_aw_o.id   = {aw_idx, slv_aw_i[aw_idx].id};
  assign mst_aw_o.addr = slv_aw_i[aw_idx].addr;
  assign mst_aw_o.len  = slv_aw_i[aw_idx].len;

  // Push once per AW; the lock keeps the AW offered without a second push
  always_comb begin
    aw_state_d     = aw_state_q;
    w_fifo_push    = 1'b0;
    mst_aw_valid_o = 1'b0;
    aw_ready       = 1'b0;
    case (aw_state_q)
      AW_LOCKED: begin
        mst_aw_valid_o = 1'b1;
        if (mst_aw_ready_i) begin
          aw_ready   = 1'b1;
          aw_state_d = AW_IDLE;
        end
      end
      default: begin
        if (aw_valid && !w_fifo_full) begin
          mst_aw_valid_o = 1'b1;
          w_fifo_push    = 1'b1;
          if (mst_aw_ready_i) begin
            aw_ready = 1'b1;
          end else begin
            aw_state_d = AW_LOCKED;   // Master stalled
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_state_q <= AW_IDLE;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

  // Grant order for the W beats
  w_route_fifo i_w_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( w_fifo_push  ),
    .data_i   ( aw_idx       ),
    .pop_i    ( w_fifo_pop   ),
    .data_o   ( w_fifo_data  ),
    .full_o   ( w_fifo_full  ),
    .empty_o  ( w_fifo_empty )
  );

  // --------------------------------------------------------------------------
  // W channel
  // --------------------------------------------------------------------------
  assign mst_w_o = slv_w_i[w_fifo_data];

  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    w_fifo_pop    = 1'b0;
    if (!w_fifo_empty) begin
      mst_w_valid_o              = slv_w_valid_i[w_fifo_data];
      slv_w_ready_o[w_fifo_data] = mst_w_ready_i;
      w_fifo_pop = slv_w_valid_i[w_fifo_data] & mst_w_ready_i & mst_w_o.last;
    end
  end

  // --------------------------------------------------------------------------
  // B channel
  // --------------------------------------------------------------------------
  assign b_sel         = mst_b_i.id[MST_ID_WIDTH-1 -: PORT_IDX_WIDTH];
  assign mst_b_ready_o = slv_b_ready_i[b_sel];

  always_comb begin
    for (int i = 0; i < NO_SLV_PORTS; i++) begin
      slv_b_o[i].id    = mst_b_i.id[SLV_ID_WIDTH-1:0];   // Port bits stripped
      slv_b_o[i].resp  = mst_b_i.resp;
      slv_b_valid_o[i] = mst_b_valid_i && (b_sel == port_idx_t'(i));
    end
  end

endmodule

// ==== verilog/axi_mux_read.sv ====
`timescale 1ns/1ps

module axi_mux_read import axi_mux_pkg::*; (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Slave ports
  input  slv_ar_chan_t [NO_SLV_PORTS-1:0] slv_ar_i,
  input  logic         [NO_SLV_PORTS-1:0] slv_ar_valid_i,
  output logic         [NO_SLV_PORTS-1:0] slv_ar_ready_o,
  output slv_r_chan_t  [NO_SLV_PORTS-1:0] slv_r_o,
  output logic         [NO_SLV_PORTS-1:0] slv_r_valid_o,
  input  logic         [NO_SLV_PORTS-1:0] slv_r_ready_i,
  // Master port
  output mst_ar_chan_t                    mst_ar_o,
  output logic                            mst_ar_valid_o,
  input  logic                            mst_ar_ready_i,
  input  mst_r_chan_t                     mst_r_i,
  input  logic                            mst_r_valid_i,
  output logic                            mst_r_ready_o
);

  port_idx_t ar_idx;
  port_idx_t r_sel;

  // --------------------------------------------------------------------------
  // AR channel
  // --------------------------------------------------------------------------
  rr_arbiter i_ar_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_ar_valid_i ),
    .gnt_i    ( mst_ar_ready_i ),
    .gnt_o    ( slv_ar_ready_o ),
    .req_o    ( mst_ar_valid_o ),
    .idx_o    ( ar_idx         )
  );

  assign mst_ar_o.id   = {ar_idx, slv_ar_i[ar_idx].id};  // Prepend port index
  assign mst_ar_o.addr = slv_ar_i[ar_idx].addr;
  assign mst_ar_o.len  = slv_ar_i[ar_idx].len;

  // --------------------------------------------------------------------------
  // R channel
  // --------------------------------------------------------------------------
  assign r_sel         = mst_r_i.id[MST_ID_WIDTH-1 -: PORT_IDX_WIDTH];
  assign mst_r_ready_o = slv_r_ready_i[r_sel];

  // Same beat to every port, valid only at the addressed one
  always_comb begin
    for (int i = 0; i < NO_SLV_PORTS; i++) begin
      slv_r_o[i].id    = mst_r_i.id[SLV_ID_WIDTH-1:0];
      slv_r_o[i].data  = mst_r_i.data;
      slv_r_o[i].resp  = mst_r_i.resp;
      slv_r_o[i].last  = mst_r_i.last;
      slv_r_valid_o[i] = mst_r_valid_i && (r_sel == port_idx_t'(i));
    end
  end

endmodule

// ==== verilog/axi_mux.sv ====
`timescale 1ns/1ps

module axi_mux import axi_mux_pkg::*; (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  slv_req_t  [NO_SLV_PORTS-1:0] slv_reqs_i,
  output slv_resp_t [NO_SLV_PORTS-1:0] slv_resps_o,
  output mst_req_t                     mst_req_o,
  input  mst_resp_t                    mst_resp_i
);

  // Per-channel views of the slave bundles
  slv_aw_chan_t [NO_SLV_PORTS-1:0] slv_aw;
  w_chan_t      [NO_SLV_PORTS-1:0] slv_w;
  slv_b_chan_t  [NO_SLV_PORTS-1:0] slv_b;
  slv_ar_chan_t [NO_SLV_PORTS-1:0] slv_ar;
  slv_r_chan_t  [NO_SLV_PORTS-1:0] slv_r;
  logic         [NO_SLV_PORTS-1:0] slv_aw_valid, slv_aw_ready;
  logic         [NO_SLV_PORTS-1:0] slv_w_valid,  slv_w_ready;
  logic         [NO_SLV_PORTS-1:0] slv_b_valid,  slv_b_ready;
  logic         [NO_SLV_PORTS-1:0] slv_ar_valid, slv_ar_ready;
  logic         [NO_SLV_PORTS-1:0] slv_r_valid,  slv_r_ready;

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_port_split
    assign slv_aw[i]       = slv_reqs_i[i].aw;
    assign slv_aw_valid[i] = slv_reqs_i[i].aw_valid;
    assign slv_w[i]        = slv_reqs_i[i].w;
    assign slv_w_valid[i]  = slv_reqs_i[i].w_valid;
    assign slv_b_ready[i]  = slv_reqs_i[i].b_ready;
    assign slv_ar[i]       = slv_reqs_i[i].ar;
    assign slv_ar_valid[i] = slv_reqs_i[i].ar_valid;
    assign slv_r_ready[i]  = slv_reqs_i[i].r_ready;

    assign slv_resps_o[i].aw_ready = slv_aw_ready[i];
    assign slv_resps_o[i].w_ready  = slv_w_ready[i];
    assign slv_resps_o[i].b        = slv_b[i];
    assign slv_resps_o[i].b_valid  = slv_b_valid[i];
    assign slv_resps_o[i].ar_ready = slv_ar_ready[i];
    assign slv_resps_o[i].r        = slv_r[i];
    assign slv_resps_o[i].r_valid  = slv_r_valid[i];
  end

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------
  axi_mux_write i_write (
    .clk_i          ( clk_i                ),
    .arst_n_i       ( arst_n_i             ),
    .slv_aw_i       ( slv_aw               ),
    .slv_aw_valid_i ( slv_aw_valid         ),
    .slv_aw_ready_o ( slv_aw_ready         ),
    .slv_w_i        ( slv_w                ),
    .slv_w_valid_i  ( slv_w_valid          ),
    .slv_w_ready_o  ( slv_w_ready          ),
    .slv_b_o        ( slv_b                ),
    .slv_b_valid_o  ( slv_b_valid          ),
    .slv_b_ready_i  ( slv_b_ready          ),
    .mst_aw_o       ( mst_req_o.aw         ),
    .mst_aw_valid_o ( mst_req_o.aw_valid   ),
    .mst_aw_ready_i ( mst_resp_i.aw_ready  ),
    .mst_w_o        ( mst_req_o.w          ),
    .mst_w_valid_o  ( mst_req_o.w_valid    ),
    .mst_w_ready_i  ( mst_resp_i.w_ready   ),
    .mst_b_i        ( mst_resp_i.b         ),
    .mst_b_valid_i  ( mst_resp_i.b_valid   ),
    .mst_b_ready_o  ( mst_req_o.b_ready    )
  );

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  axi_mux_read i_read (
    .clk_i          ( clk_i                ),
    .arst_n_i       ( arst_n_i             ),
    .slv_ar_i       ( slv_ar               ),
    .slv_ar_valid_i ( slv_ar_valid         ),
    .slv_ar_ready_o ( slv_ar_ready         ),
    .slv_r_o        ( slv_r                ),
    .slv_r_valid_o  ( slv_r_valid          ),
    .slv_r_ready_i  ( slv_r_ready          ),
    .mst_ar_o       ( mst_req_o.ar         ),
    .mst_ar_valid_o ( mst_req_o.ar_valid   ),
    .mst_ar_ready_i ( mst_resp_i.ar_ready  ),
    .mst_r_i        ( mst_resp_i.r         ),
    .mst_r_valid_i  ( mst_resp_i.r_valid   ),
    .mst_r_ready_o  ( mst_req_o.r_ready    )
  );

endmodule

// ==== tb/axi_mux_asserts.sv ====
`timescale 1ns/1ps

module axi_mux_asserts import axi_mux_pkg::*; (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input mst_aw_chan_t            mst_aw_o,
  input logic                    mst_aw_valid_o,
  input logic                    mst_aw_ready_i,
  input logic [NO_SLV_PORTS-1:0] slv_b_valid_o,
  input w_chan_t                 mst_w_o,
  input logic                    mst_w_valid_o,
  input logic                    mst_w_ready_i,
  input logic                    w_fifo_push
);

  int unsigned fail_cnt = 0;  // Failed assertions so far
  int unsigned w_open_q;      // Pushed writes still waiting for their last W beat
  logic        w_last_done;

  assign w_last_done = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_open_q <= 0;
    end else begin
      w_open_q <= w_open_q + w_fifo_push - w_last_done;
    end
  end

  // A stalled AW keeps valid and payload until its transfer
  aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
    else begin
      $error("Master AW changed or dropped before its transfer");
      fail_cnt++;
    end

  b_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(slv_b_valid_o))
    else begin
      $error("More than one slave port sees b_valid");
      fail_cnt++;
    end

  w_needs_route: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_w_valid_o |-> w_open_q != 0)
    else begin
      $error("Master w_valid high with no write in the route FIFO");
      fail_cnt++;
    end

  no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      w_fifo_push |-> w_open_q < MAX_W_TRANS)
    else begin
      $error("Route FIFO pushed while full");
      fail_cnt++;
    end

endmodule

bind axi_mux_write axi_mux_asserts i_asserts (.*);

// ==== tb/tb_axi_mux.sv ====
`timescale 1ns/1ps

module tb_axi_mux import axi_mux_pkg::*; ();

  localparam int unsigned TIMEOUT_CYCLES = 2000;  // Well above the length of all tests together

  logic                         clk_i;
  logic                         arst_n_i;
  slv_req_t  [NO_SLV_PORTS-1:0] slv_reqs;
  slv_resp_t [NO_SLV_PORTS-1:0] slv_resps;
  mst_req_t                     mst_req;
  mst_resp_t                    mst_resp;

  string        test_name;
  int unsigned  err_cnt        = 0;
  int unsigned  test_err_start = 0;
  int unsigned  tests_passed   = 0;
  int unsigned  tests_failed   = 0;
  int unsigned  cycle_cnt      = 0;
  logic [31:0]  rng_state      = 32'd99;
  slv_aw_chan_t aw_sent [NO_SLV_PORTS];   // AWs offered by issue_all_aws

  axi_mux DUT (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .slv_reqs_i  ( slv_reqs  ),
    .slv_resps_o ( slv_resps ),
    .mst_req_o   ( mst_req   ),
    .mst_resp_i  ( mst_resp  )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [NO_SLV_PORTS-1:0] aw_readies();
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      aw_readies[p] = slv_resps[p].aw_ready;
    end
  endfunction

  function automatic logic [NO_SLV_PORTS-1:0] ar_readies();
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      ar_readies[p] = slv_resps[p].ar_ready;
    end
  endfunction

  function automatic logic [NO_SLV_PORTS-1:0] b_valids();
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      b_valids[p] = slv_resps[p].b_valid;
    end
  endfunction

  function automatic logic [NO_SLV_PORTS-1:0] r_valids();
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      r_valids[p] = slv_resps[p].r_valid;
    end
  endfunction

  // Wait until 1 ns after the next rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic apply_reset();
    arst_n_i = 1'b0;
    slv_reqs = '0;
    mst_resp = '0;
    repeat (4) step();
    arst_n_i = 1'b1;
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
    apply_reset();
  endtask

  task automatic end_test();
    if (err_cnt == test_err_start) begin
      tests_passed++;
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, err_cnt - test_err_start);
    end
  endtask

  // All four ports offer an AW at once and are granted in order 0 to 3
  task automatic issue_all_aws(input len_t len);
    mst_aw_chan_t exp_aw;
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      aw_sent[p]           = {slv_id_t'(next_rand()), next_rand(), len};
      slv_reqs[p].aw       = aw_sent[p];
      slv_reqs[p].aw_valid = 1'b1;
    end
    mst_resp.aw_ready = 1'b1;
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      #1;
      exp_aw = {port_idx_t'(p), aw_sent[p].id, aw_sent[p].addr, aw_sent[p].len};
      check_val("AW valid", 1, mst_req.aw_valid);
      check_val("AW payload", exp_aw, mst_req.aw);
      check_val("AW grant", 4'b0001 << p, aw_readies());
      step();
      slv_reqs[p].aw_valid = 1'b0;
    end
    mst_resp.aw_ready = 1'b0;
  endtask

  // One burst from port p with each beat awaited and compared on the master
  task automatic send_w_burst(input int p, input int nbeats);
    w_chan_t beat;
    for (int b = 0; b < nbeats; b++) begin
      beat                = {next_rand(), 4'hf, (b == nbeats - 1)};
      slv_reqs[p].w       = beat;
      slv_reqs[p].w_valid = 1'b1;
      #1;
      while (!(mst_req.w_valid && mst_resp.w_ready)) begin
        step();
        #1;
      end
      check_val("W beat", beat, mst_req.w);
      check_val("W ready", 1, slv_resps[p].w_ready);
      step();
    end
    slv_reqs[p].w_valid = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_single_write();
    slv_aw_chan_t aw;
    mst_aw_chan_t exp_aw;
    slv_b_chan_t  exp_b;
    start_test("single_write");
    check_val("valids after reset", '0,
              {mst_req.aw_valid, mst_req.w_valid, mst_req.ar_valid, b_valids(), r_valids()});
    aw                   = {slv_id_t'(next_rand()), next_rand(), 8'd2};  // Three beats
    slv_reqs[2].aw       = aw;
    slv_reqs[2].aw_valid = 1'b1;
    mst_resp.aw_ready    = 1'b1;
    mst_resp.w_ready     = 1'b1;
    #1;
    exp_aw = {port_idx_t'(2), aw.id, aw.addr, aw.len};
    check_val("AW valid", 1, mst_req.aw_valid);
    check_val("AW payload", exp_aw, mst_req.aw);
    check_val("AW grant", 4'b0100, aw_readies());
    step();
    slv_reqs[2].aw_valid = 1'b0;
    send_w_burst(2, 3);
    mst_resp.b.id       = {port_idx_t'(2), aw.id};
    mst_resp.b.resp     = SLVERR;
    mst_resp.b_valid    = 1'b1;
    slv_reqs[2].b_ready = 1'b1;
    #1;
    exp_b = {aw.id, SLVERR};
    check_val("B valid", 4'b0100, b_valids());
    check_val("B payload", exp_b, slv_resps[2].b);
    check_val("B ready", 1, mst_req.b_ready);
    step();
    mst_resp.b_valid = 1'b0;
    end_test();
  endtask

  task automatic test_write_order();
    w_chan_t                 beats [NO_SLV_PORTS][2];
    int                      sent  [NO_SLV_PORTS];
    w_chan_t                 exp_q [$];
    logic [NO_SLV_PORTS-1:0] fire;
    start_test("write_order");
    issue_all_aws(8'd1);
    for (int p = 0; p < NO_SLV_PORTS; p++) begin
      sent[p] = 0;
      for (int b = 0; b < 2; b++) begin
        beats[p][b] = {next_rand(), 4'hf, (b == 1)};
        exp_q.push_back(beats[p][b]);       // Grant order
      end
    end
    mst_resp.w_ready = 1'b1;
    for (int c = 0; c < 40 && exp_q.size() > 0; c++) begin
      // w_valid rises on port 3 first and on port 0 last
      if (c < NO_SLV_PORTS) begin
        slv_reqs[3-c].w       = beats[3-c][0];
        slv_reqs[3-c].w_valid = 1'b1;
      end
      #1;
      fire = '0;
      if (mst_req.w_valid) begin
        check_val("W beat in grant order", exp_q[0], mst_req.w);
        void'(exp_q.pop_front());
        for (int p = 0; p < NO_SLV_PORTS; p++) begin
          fire[p] = slv_reqs[p].w_valid & slv_resps[p].w_ready;
        end
        check_val("ports taking a W beat", 1, $countones(fire));
      end
      step();
      for (int p = 0; p < NO_SLV_PORTS; p++) begin
        if (fire[p]) begin
          sent[p]++;
          if (sent[p] == 2) begin
            slv_reqs[p].w_valid = 1'b0;
          end else begin
            slv_reqs[p].w = beats[p][sent[p]];
          end
        end
      end
    end
    check_val("W beats never seen", 0, exp_q.size());
    mst_resp.w_ready = 1'b0;
    end_test();
  endtask

  task automatic test_aw_backpressure();
    slv_aw_chan_t aw3, aw0;
    mst_aw_chan_t exp3, exp0;
    start_test("aw_backpressure");
    aw3                  = {slv_id_t'(next_rand()), next_rand(), 8'd0};
    aw0                  = {slv_id_t'(next_rand()), next_rand(), 8'd3};
    exp3                 = {port_idx_t'(3), aw3.id, aw3.addr, aw3.len};
    exp0                 = {port_idx_t'(0), aw0.id, aw0.addr, aw0.len};
    slv_reqs[3].aw       = aw3;
    slv_reqs[3].aw_valid = 1'b1;
    for (int c = 0; c < 5; c++) begin
      // Port 0 has the higher priority but comes one cycle late
      if (c == 1) begin
        slv_reqs[0].aw       = aw0;
        slv_reqs[0].aw_valid = 1'b1;
      end
      #1;
      check_val("stalled AW valid", 1, mst_req.aw_valid);
      check_val("stalled AW payload", exp3, mst_req.aw);
      check_val("AW readies while stalled", 0, aw_readies());
      step();
    end
    mst_resp.aw_ready = 1'b1;
    #1;
    check_val("AW payload at accept", exp3, mst_req.aw);
    check_val("AW grant at accept", 4'b1000, aw_readies());
    step();
    slv_reqs[3].aw_valid = 1'b0;
    #1;
    check_val("next AW payload", exp0, mst_req.aw);
    check_val("next AW grant", 4'b0001, aw_readies());
    step();
    slv_reqs[0].aw_valid = 1'b0;
    mst_resp.aw_ready    = 1'b0;
    end_test();
  endtask

  task automatic test_outstanding_limit();
    slv_aw_chan_t aw5;
    mst_aw_chan_t exp5;
    start_test("outstanding_limit");
    issue_all_aws(8'd1);
    aw5                  = {slv_id_t'(next_rand()), next_rand(), 8'd0};
    exp5                 = {port_idx_t'(1), aw5.id, aw5.addr, aw5.len};
    slv_reqs[1].aw       = aw5;
    slv_reqs[1].aw_valid = 1'b1;
    mst_resp.aw_ready    = 1'b1;
    for (int c = 0; c < 3; c++) begin
      #1;
      check_val("AW valid with four outstanding", 0, mst_req.aw_valid);
      check_val("AW readies with four outstanding", 0, aw_readies());
      step();
    end
    mst_resp.w_ready = 1'b1;
    send_w_burst(0, 2);
    #1;
    check_val("AW valid after W burst", 1, mst_req.aw_valid);
    check_val("AW payload after W burst", exp5, mst_req.aw);
    check_val("AW grant after W burst", 4'b0010, aw_readies());
    step();
    slv_reqs[1].aw_valid = 1'b0;
    mst_resp.aw_ready    = 1'b0;
    mst_resp.w_ready     = 1'b0;
    end_test();
  endtask

  task automatic test_read_routing();
    slv_ar_chan_t ar [NO_SLV_PORTS];
    mst_ar_chan_t exp_ar;
    slv_r_chan_t  exp_r;
    data_t        data;
    int           p;
    start_test("read_routing");
    for (int i = 0; i < 2; i++) begin
      p                    = 2 * i;
      ar[p]                = {slv_id_t'(next_rand()), next_rand(), 8'd1};
      slv_reqs[p].ar       = ar[p];
      slv_reqs[p].ar_valid = 1'b1;
      slv_reqs[p].r_ready  = 1'b1;
    end
    mst_resp.ar_ready = 1'b1;
    for (int i = 0; i < 2; i++) begin
      p = 2 * i;
      #1;
      exp_ar = {port_idx_t'(p), ar[p].id, ar[p].addr, ar[p].len};
      check_val("AR valid", 1, mst_req.ar_valid);
      check_val("AR payload", exp_ar, mst_req.ar);
      check_val("AR grant", 4'b0001 << p, ar_readies());
      step();
      slv_reqs[p].ar_valid = 1'b0;
    end
    mst_resp.ar_ready = 1'b0;
    // Beats alternate between ports 2 and 0
    for (int b = 0; b < 4; b++) begin
      p                = (b % 2 == 0) ? 2 : 0;
      data             = next_rand();
      mst_resp.r.id    = {port_idx_t'(p), ar[p].id};
      mst_resp.r.data  = data;
      mst_resp.r.resp  = OKAY;
      mst_resp.r.last  = (b >= 2);
      mst_resp.r_valid = 1'b1;
      exp_r            = {ar[p].id, data, OKAY, (b >= 2)};
      if (b == 1) begin
        slv_reqs[p].r_ready = 1'b0;
        repeat (2) begin
          #1;
          check_val("R ready while port stalls", 0, mst_req.r_ready);
          check_val("R valid while port stalls", 4'b0001 << p, r_valids());
          step();
        end
        slv_reqs[p].r_ready = 1'b1;
      end
      #1;
      check_val("R valid", 4'b0001 << p, r_valids());
      check_val("R payload", exp_r, slv_resps[p].r);
      check_val("R ready", 1, mst_req.r_ready);
      step();
    end
    mst_resp.r_valid = 1'b0;
    end_test();
  endtask

  // --------------------------------------------------------------------------
  // Sequence
  // --------------------------------------------------------------------------
  initial begin
    arst_n_i = 1'b0;
    slv_reqs = '0;
    mst_resp = '0;
    test_single_write();
    test_write_order();
    test_aw_backpressure();
    test_outstanding_limit();
    test_read_routing();
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, DUT.i_write.i_asserts.fail_cnt);
    if (tests_failed == 0 && DUT.i_write.i_asserts.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/axi_mux_pkg.sv
verilog/rr_arbiter.sv
verilog/w_route_fifo.sv
verilog/axi_mux_write.sv
verilog/axi_mux_read.sv
verilog/axi_mux.sv
tb/axi_mux_asserts.sv
tb/tb_axi_mux.sv

// ==== Bender.yml ====
package:
  name: axi_mux

sources:
  - verilog/axi_mux_pkg.sv
  - verilog/rr_arbiter.sv
  - verilog/w_route_fifo.sv
  - verilog/axi_mux_write.sv
  - verilog/axi_mux_read.sv
  - verilog/axi_mux.sv
  - target: test
    files:
      - tb/axi_mux_asserts.sv
      - tb/tb_axi_mux.sv
